// File: run_sim.sh
#!/bin/sh
# Compile and run the input front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_input_frontend \
    -f sim.f

out=$(./obj_dir/Vtb_input_frontend)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// File: sim.f
+incdir+include
verilog/input_pkg.sv
verilog/rotary_conditioner.sv
verilog/dip_switch_bank.sv
verilog/input_frontend_top.sv
testbench/tb_input_frontend.sv

// File: include/input_ref.svh
//==============================
// Expected-value functions for the testbench, written apart from the RTL
//==============================
`ifndef INPUT_REF_SVH
`define INPUT_REF_SVH

// Scaling on signed integers, truncated back to a byte
function automatic logic [7:0] ref_scale(input logic [7:0] d, input logic [2:0] sens,
                                         input logic invert);
    int          v;
    int          s;
    logic [7:0]  r;
    v = d[7] ? int'(d) - 256 : int'(d);  // Sign-extend
    if (sens <= 3'd4) begin
        s = v >>> sens;
    end else if (sens == 3'd5) begin
        s = v * 2;
    end else if (sens == 3'd6) begin
        s = v + (v >>> 1);
    end else begin
        s = v + (v >>> 2);
    end
    r = s[7:0];
    return (invert && (r != 8'h00)) ? ~r : r;
endfunction

// Expected rotary byte for one player
function automatic logic [7:0] ref_rotary(input logic [1:0] mode, input logic [7:0] x,
                                          input logic [7:0] paddle, input logic [8:0] spin,
                                          input logic prev_tog, input logic [1:0] dpad,
                                          input logic [2:0] sens, input logic invert);
    logic [7:0] raw;
    case (mode)
        input_pkg::MODE_JOYSTICK: raw = x;
        input_pkg::MODE_PADDLE:   raw = paddle - input_pkg::PADDLE_CENTER;
        input_pkg::MODE_SPINNER:  raw = (spin[8] != prev_tog) ? spin[7:0] : 8'h00;
        default:                  raw = dpad[0] ? input_pkg::DPAD_RATE_RIGHT :
                                        dpad[1] ? input_pkg::DPAD_RATE_LEFT : 8'h00;
    endcase
    return ref_scale(raw, sens, invert);
endfunction

// Next stored active-low DIP byte for bank sel
function automatic logic [7:0] ref_dip_next(input logic [7:0] cur, input logic wr,
                                            input logic [7:0] index, input logic [24:0] addr,
                                            input logic [7:0] dout, input logic sel);
    logic hit;
    hit = wr && (index == input_pkg::DIP_INDEX) && (addr == {24'd0, sel});
    return hit ? dout : cur;
endfunction

`endif

// File: testbench/tb_input_frontend.sv
`timescale 1ns/1ps
//==============================
// Rotary and DIP outputs are checked one cycle after the drive, buttons in the same cycle
// Stimulus comes from a fixed xorshift seed, so every run is identical
//==============================
module tb_input_frontend;
    import input_pkg::*;

    `include "input_ref.svh"

    localparam int drive_dly   = 10;                   // ns after the rising edge
    localparam int test_cycles = 200;
    localparam int max_cycles  = 6 * test_cycles + 800;  // Six tests plus reset and margin

    logic                    clk_sys;
    logic                    arst_n;
    logic [JOY_W-1:0]        joystick_p1, joystick_p2, joystick_p3, joystick_p4;
    logic [ANALOG_W-1:0]     analog_x_p1, analog_x_p2, paddle_p1, paddle_p2;
    logic [SPIN_W-1:0]       spinner_p1, spinner_p2;
    logic [1:0]              analog_mode;
    logic [2:0]              analog_sens;
    logic                    analog_invert;
    logic                    ioctl_wr;
    logic [7:0]              ioctl_index;
    logic [IOCTL_ADDR_W-1:0] ioctl_addr;
    logic [7:0]              ioctl_dout;
    logic [ANALOG_W-1:0]     analog_p1, analog_p2;
    logic                    analog_abs, analog_inc;
    logic [7:0]              dswa, dswb;
    logic [3:0]              start, coin;
    logic                    pause_btn;

    logic [31:0] rng;
    int          cycle_cnt = 0;
    int          err_count = 0;
    int          err_mark  = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       cur_test = "none";

    // Reference model state
    logic [1:0]  m_prev_tog;          // {p2, p1}
    logic [7:0]  m_dip_a, m_dip_b;    // Stored active low
    logic [7:0]  exp_p1, exp_p2;
    logic        exp_abs, exp_inc;
    logic [3:0]  exp_start, exp_coin;
    logic        exp_pause;

    input_frontend_top dut (
        .clk_sys(clk_sys), .arst_n(arst_n),
        .joystick_p1(joystick_p1), .joystick_p2(joystick_p2),
        .joystick_p3(joystick_p3), .joystick_p4(joystick_p4),
        .analog_x_p1(analog_x_p1), .analog_x_p2(analog_x_p2),
        .paddle_p1(paddle_p1), .paddle_p2(paddle_p2),
        .spinner_p1(spinner_p1), .spinner_p2(spinner_p2),
        .analog_mode(analog_mode), .analog_sens(analog_sens),
        .analog_invert(analog_invert),
        .ioctl_wr(ioctl_wr), .ioctl_index(ioctl_index),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
        .analog_p1(analog_p1), .analog_p2(analog_p2),
        .analog_abs(analog_abs), .analog_inc(analog_inc),
        .dswa(dswa), .dswb(dswb),
        .start(start), .coin(coin), .pause_btn(pause_btn)
    );

    //==============================
    // Clock, cycle count, timeout
    //==============================
    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= max_cycles);
        $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    //==============================
    // Stimulus helpers
    //==============================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_drive_slot();
        @(posedge clk_sys);
        #drive_dly;
    endtask

    task automatic randomize_players();
        rng = xorshift(rng);
        joystick_p1 = rng[15:0];
        joystick_p2 = rng[31:16];
        rng = xorshift(rng);
        joystick_p3 = rng[15:0];
        joystick_p4 = rng[31:16];
        rng = xorshift(rng);
        analog_x_p1 = rng[7:0];
        analog_x_p2 = rng[15:8];
        paddle_p1   = rng[23:16];
        paddle_p2   = rng[31:24];
        rng = xorshift(rng);
        spinner_p1  = rng[8:0];   // Toggle bit random, so about half the cycles flip
        spinner_p2  = rng[24:16];
    endtask

    task automatic randomize_scaling();
        rng = xorshift(rng);
        analog_sens   = rng[2:0];
        analog_invert = rng[3];
    endtask

    task automatic randomize_download();
        rng = xorshift(rng);
        ioctl_wr    = rng[0];
        ioctl_index = rng[1] ? DIP_INDEX : rng[15:8];
        case (rng[3:2])
            2'd0:    ioctl_addr = '0;
            2'd1:    ioctl_addr = 25'd1;
            2'd2:    ioctl_addr = 25'd2;
            default: ioctl_addr = {rng[31:16], 9'd0};  // Far above the DIP bytes
        endcase
        rng = xorshift(rng);
        ioctl_dout = rng[7:0];
    endtask

    task automatic report_mismatch(input string msg);
        err_count++;
        $display("FAILED t=%0t %s: %s", $time, cur_test, msg);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = err_count;
    endtask

    // Lets the compare process see the last drive before the result is counted
    task automatic end_test();
        @(negedge clk_sys);
        @(negedge clk_sys);
        #1;
        tests_run++;
        if (err_count != err_mark) begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", cur_test, err_count - err_mark);
        end else begin
            $display("Test %s: ok", cur_test);
        end
    endtask

    //==============================
    // Reference model and compare
    //==============================
    initial begin
        forever begin
            @(posedge clk_sys);
            if (!arst_n) begin
                m_prev_tog = '0;
                m_dip_a    = 8'hff;
                m_dip_b    = 8'hff;
                exp_p1     = '0;
                exp_p2     = '0;
                exp_abs    = 1'b0;
                exp_inc    = 1'b0;
            end else begin
                exp_p1  = ref_rotary(analog_mode, analog_x_p1, paddle_p1, spinner_p1,
                                     m_prev_tog[0], joystick_p1[1:0], analog_sens, analog_invert);
                exp_p2  = ref_rotary(analog_mode, analog_x_p2, paddle_p2, spinner_p2,
                                     m_prev_tog[1], joystick_p2[1:0], analog_sens, analog_invert);
                exp_abs = (analog_mode != MODE_SPINNER);
                exp_inc = (analog_mode == MODE_SPINNER)
                       && ((spinner_p1[8] != m_prev_tog[0]) || (spinner_p2[8] != m_prev_tog[1]));
                m_prev_tog = {spinner_p2[8], spinner_p1[8]};
                m_dip_a = ref_dip_next(m_dip_a, ioctl_wr, ioctl_index, ioctl_addr, ioctl_dout, 1'b0);
                m_dip_b = ref_dip_next(m_dip_b, ioctl_wr, ioctl_index, ioctl_addr, ioctl_dout, 1'b1);
            end
            @(negedge clk_sys);  // Outputs settled, inputs steady
            exp_start = {joystick_p4[10], joystick_p3[10], joystick_p2[10], joystick_p1[10]};
            exp_coin  = {joystick_p4[11], joystick_p3[11], joystick_p2[11], joystick_p1[11]};
            exp_pause = joystick_p1[12] | joystick_p2[12] | joystick_p3[12] | joystick_p4[12];
            if (analog_p1 !== exp_p1) begin
                report_mismatch($sformatf("analog_p1 got %h expected %h", analog_p1, exp_p1));
            end
            if (analog_p2 !== exp_p2) begin
                report_mismatch($sformatf("analog_p2 got %h expected %h", analog_p2, exp_p2));
            end
            if (analog_abs !== exp_abs) begin
                report_mismatch($sformatf("analog_abs got %b expected %b", analog_abs, exp_abs));
            end
            if (analog_inc !== exp_inc) begin
                report_mismatch($sformatf("analog_inc got %b expected %b", analog_inc, exp_inc));
            end
            if (dswa !== ~m_dip_a) begin
                report_mismatch($sformatf("dswa got %h expected %h", dswa, ~m_dip_a));
            end
            if (dswb !== ~m_dip_b) begin
                report_mismatch($sformatf("dswb got %h expected %h", dswb, ~m_dip_b));
            end
            if (start !== exp_start) begin
                report_mismatch($sformatf("start got %b expected %b", start, exp_start));
            end
            if (coin !== exp_coin) begin
                report_mismatch($sformatf("coin got %b expected %b", coin, exp_coin));
            end
            if (pause_btn !== exp_pause) begin
                report_mismatch($sformatf("pause_btn got %b expected %b", pause_btn, exp_pause));
            end
        end
    end

    //==============================
    // Test sequence
    //==============================
    initial begin
        arst_n = 1'b0;
        rng = 32'h210c;
        {joystick_p1, joystick_p2, joystick_p3, joystick_p4} = '0;
        {analog_x_p1, analog_x_p2, paddle_p1, paddle_p2} = '0;
        {spinner_p1, spinner_p2} = '0;
        analog_mode   = MODE_JOYSTICK;
        analog_sens   = 3'd0;
        analog_invert = 1'b0;
        ioctl_wr      = 1'b0;
        ioctl_index   = 8'd0;
        ioctl_addr    = '0;
        ioctl_dout    = 8'd0;

        begin_test("reset");
        repeat (5) @(posedge clk_sys);
        #drive_dly;
        arst_n = 1'b1;
        end_test();

        begin_test("joystick_paddle");
        for (int m = 0; m < 2; m++) begin
            for (int s = 0; s < 8; s++) begin
                for (int inv = 0; inv < 2; inv++) begin
                    repeat (6) begin
                        next_drive_slot();
                        analog_mode   = (m != 0) ? MODE_PADDLE : MODE_JOYSTICK;
                        analog_sens   = 3'(s);
                        analog_invert = 1'(inv);
                        randomize_players();
                    end
                end
            end
        end
        end_test();

        begin_test("spinner");
        repeat (test_cycles) begin
            next_drive_slot();
            analog_mode = MODE_SPINNER;
            randomize_scaling();
            randomize_players();
        end
        end_test();

        begin_test("dpad");
        repeat (test_cycles) begin
            next_drive_slot();
            analog_mode = MODE_DPAD;
            randomize_scaling();
            randomize_players();   // Bits 1:0 cover all four D-pad states
        end
        end_test();

        begin_test("dip_capture");
        repeat (test_cycles) begin
            next_drive_slot();
            randomize_scaling();
            analog_mode = rng[5:4];
            randomize_players();
            randomize_download();
        end
        next_drive_slot();
        ioctl_wr = 1'b0;
        end_test();

        begin_test("buttons");
        repeat (test_cycles) begin
            next_drive_slot();
            randomize_scaling();
            analog_mode = rng[5:4];
            randomize_players();
        end
        end_test();

        $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/dip_switch_bank.sv
`timescale 1ns/1ps
//==============================
// Only DIP bytes 0 and 1 are kept; higher addresses are ignored
// Switches are stored active low and driven out active high
//==============================
module dip_switch_bank (
    input  logic                                clk_sys,
    input  logic                                arst_n,
    input  logic                                ioctl_wr,
    input  logic [7:0]                          ioctl_index,
    input  logic [input_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
    input  logic [7:0]                          ioctl_dout,
    output logic [7:0]                          dswa,
    output logic [7:0]                          dswb
);
    import input_pkg::*;

    logic [7:0] dip_sw_a;  // Active low, bank A
    logic [7:0] dip_sw_b;  // Active low, bank B
    logic       dip_wr;

    // Address 0 or 1 at the DIP index
    assign dip_wr = ioctl_wr
                 && (ioctl_index == DIP_INDEX)
                 && (ioctl_addr[IOCTL_ADDR_W-1:1] == '0);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            dip_sw_a <= 8'hff;  // All switches off
            dip_sw_b <= 8'hff;
        end else if (dip_wr) begin
            if (ioctl_addr[0]) begin
                dip_sw_b <= ioctl_dout;
            end else begin
                dip_sw_a <= ioctl_dout;
            end
        end
    end

    assign dswa = ~dip_sw_a;
    assign dswb = ~dip_sw_b;

    // Bank A write is visible, inverted, on the following cycle
    a_dswa_capture: assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        (ioctl_wr && (ioctl_index == DIP_INDEX) && (ioctl_addr == '0))
        |=> (dswa == ~$past(ioctl_dout))
    );

endmodule

// File: verilog/input_frontend_top.sv
`timescale 1ns/1ps
//==============================
// Rotary and DIP outputs are registered; button outputs are combinational
//==============================
module input_frontend_top (
    input  logic                                clk_sys,
    input  logic                                arst_n,
    input  logic [input_pkg::JOY_W-1:0]         joystick_p1,
    input  logic [input_pkg::JOY_W-1:0]         joystick_p2,
    input  logic [input_pkg::JOY_W-1:0]         joystick_p3,
    input  logic [input_pkg::JOY_W-1:0]         joystick_p4,
    input  logic [input_pkg::ANALOG_W-1:0]      analog_x_p1,
    input  logic [input_pkg::ANALOG_W-1:0]      analog_x_p2,
    input  logic [input_pkg::ANALOG_W-1:0]      paddle_p1,
    input  logic [input_pkg::ANALOG_W-1:0]      paddle_p2,
    input  logic [input_pkg::SPIN_W-1:0]        spinner_p1,
    input  logic [input_pkg::SPIN_W-1:0]        spinner_p2,
    input  logic [1:0]                          analog_mode,
    input  logic [2:0]                          analog_sens,
    input  logic                                analog_invert,
    input  logic                                ioctl_wr,
    input  logic [7:0]                          ioctl_index,
    input  logic [input_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
    input  logic [7:0]                          ioctl_dout,
    output logic [input_pkg::ANALOG_W-1:0]      analog_p1,
    output logic [input_pkg::ANALOG_W-1:0]      analog_p2,
    output logic                                analog_abs,
    output logic                                analog_inc,
    output logic [7:0]                          dswa,
    output logic [7:0]                          dswb,
    output logic [3:0]                          start,      // Player 4 in MSB
    output logic [3:0]                          coin,
    output logic                                pause_btn
);
    import input_pkg::*;

    //==============================
    // Rotary inputs
    //==============================
    rotary_conditioner u_rotary (
        .clk_sys       (clk_sys),
        .arst_n        (arst_n),
        .dpad_p1       ({joystick_p1[JOY_LEFT_BIT], joystick_p1[JOY_RIGHT_BIT]}),
        .dpad_p2       ({joystick_p2[JOY_LEFT_BIT], joystick_p2[JOY_RIGHT_BIT]}),
        .analog_x_p1   (analog_x_p1),
        .analog_x_p2   (analog_x_p2),
        .paddle_p1     (paddle_p1),
        .paddle_p2     (paddle_p2),
        .spinner_p1    (spinner_p1),
        .spinner_p2    (spinner_p2),
        .analog_mode   (analog_mode),
        .analog_sens   (analog_sens),
        .analog_invert (analog_invert),
        .analog_p1     (analog_p1),
        .analog_p2     (analog_p2),
        .analog_abs    (analog_abs),
        .analog_inc    (analog_inc)
    );

    // DIP bytes from the download stream
    dip_switch_bank u_dip (
        .clk_sys     (clk_sys),
        .arst_n      (arst_n),
        .ioctl_wr    (ioctl_wr),
        .ioctl_index (ioctl_index),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .dswa        (dswa),
        .dswb        (dswb)
    );

    //==============================
    // Button packing
    //==============================
    assign start = {joystick_p4[BTN_START], joystick_p3[BTN_START],
                    joystick_p2[BTN_START], joystick_p1[BTN_START]};

    assign coin = {joystick_p4[BTN_COIN], joystick_p3[BTN_COIN],
                   joystick_p2[BTN_COIN], joystick_p1[BTN_COIN]};

    // Any player can pause
    assign pause_btn = joystick_p1[BTN_PAUSE] | joystick_p2[BTN_PAUSE]
                     | joystick_p3[BTN_PAUSE] | joystick_p4[BTN_PAUSE];

endmodule

// File: verilog/input_pkg.sv
//==============================
// Shared widths, bit positions and mode codes for the player input front end
// Scaling wraps modulo 256; invert never turns a zero into 0xff
//==============================
package input_pkg;

    //==============================
    // Word widths
    //==============================
    localparam int JOY_W        = 16;  // Host joystick word
    localparam int ANALOG_W     = 8;   // Rotary or analog byte
    localparam int SPIN_W       = 9;   // Toggle in MSB, signed delta below
    localparam int IOCTL_ADDR_W = 25;  // Download stream address

    // Joystick word bit positions
    localparam int JOY_RIGHT_BIT = 0;
    localparam int JOY_LEFT_BIT  = 1;
    localparam int BTN_START     = 10;
    localparam int BTN_COIN      = 11;
    localparam int BTN_PAUSE     = 12;

    //==============================
    // Rotary source selection
    //==============================
    localparam logic [1:0] MODE_JOYSTICK = 2'd0;
    localparam logic [1:0] MODE_PADDLE   = 2'd1;
    localparam logic [1:0] MODE_SPINNER  = 2'd2;
    localparam logic [1:0] MODE_DPAD     = 2'd3;

    localparam logic [ANALOG_W-1:0] PADDLE_CENTER   = 8'h7f;  // Paddle midpoint
    localparam logic [ANALOG_W-1:0] DPAD_RATE_RIGHT = 8'h40;
    localparam logic [ANALOG_W-1:0] DPAD_RATE_LEFT  = 8'hc0;  // Negative rate

    // Download index that carries DIP switch bytes
    localparam logic [7:0] DIP_INDEX = 8'd254;

    //==============================
    // Sensitivity scaler
    //==============================
    // Settings 0..4 attenuate by shifting, 5..7 boost to 200, 150 and 125 percent
    function automatic logic [ANALOG_W-1:0] sens_scale(
        input logic [ANALOG_W-1:0] d,
        input logic [2:0]          sens,
        input logic                invert
    );
        logic [ANALOG_W-1:0] r;
        case (sens)
            3'd0: r = d;
            3'd1: r = ANALOG_W'($signed(d) >>> 1);
            3'd2: r = ANALOG_W'($signed(d) >>> 2);
            3'd3: r = ANALOG_W'($signed(d) >>> 3);
            3'd4: r = ANALOG_W'($signed(d) >>> 4);
            3'd5: r = d + d;
            3'd6: r = d + ANALOG_W'($signed(d) >>> 1);
            3'd7: r = d + ANALOG_W'($signed(d) >>> 2);
        endcase
        // Zero stays zero so an idle input reads as no motion
        if (invert && (r != '0)) begin
            r = ~r;
        end
        return r;
    endfunction

endpackage

// File: verilog/rotary_conditioner.sv
`timescale 1ns/1ps
//==============================
// Outputs lag the inputs by one clock, one result every cycle
// Spinner deltas count only on a toggle flip; other modes report absolute
//==============================
module rotary_conditioner (
    input  logic                            clk_sys,
    input  logic                            arst_n,
    input  logic [1:0]                      dpad_p1,      // Joystick bits 1:0
    input  logic [1:0]                      dpad_p2,
    input  logic [input_pkg::ANALOG_W-1:0]  analog_x_p1,
    input  logic [input_pkg::ANALOG_W-1:0]  analog_x_p2,
    input  logic [input_pkg::ANALOG_W-1:0]  paddle_p1,
    input  logic [input_pkg::ANALOG_W-1:0]  paddle_p2,
    input  logic [input_pkg::SPIN_W-1:0]    spinner_p1,
    input  logic [input_pkg::SPIN_W-1:0]    spinner_p2,
    input  logic [1:0]                      analog_mode,
    input  logic [2:0]                      analog_sens,
    input  logic                            analog_invert,
    output logic [input_pkg::ANALOG_W-1:0]  analog_p1,
    output logic [input_pkg::ANALOG_W-1:0]  analog_p2,
    output logic                            analog_abs,
    output logic                            analog_inc
);
    import input_pkg::*;

    logic [1:0]          prev_toggle;  // {p2, p1} toggle from last cycle
    logic [1:0]          spin_flip;
    logic [ANALOG_W-1:0] raw_p1;
    logic [ANALOG_W-1:0] raw_p2;
    logic                abs_next;
    logic                inc_next;

    // D-pad synthesises a fixed rate, right wins when both are held
    function automatic logic [ANALOG_W-1:0] dpad_rate(input logic [1:0] dpad);
        logic [ANALOG_W-1:0] rate;
        if (dpad[JOY_RIGHT_BIT]) begin
            rate = DPAD_RATE_RIGHT;
        end else if (dpad[JOY_LEFT_BIT]) begin
            rate = DPAD_RATE_LEFT;
        end else begin
            rate = '0;
        end
        return rate;
    endfunction

    assign spin_flip[0] = spinner_p1[SPIN_W-1] ^ prev_toggle[0];
    assign spin_flip[1] = spinner_p2[SPIN_W-1] ^ prev_toggle[1];

    //==============================
    // Source selection
    //==============================
    always_comb begin
        raw_p1   = '0;
        raw_p2   = '0;
        abs_next = 1'b1;
        inc_next = 1'b0;
        case (analog_mode)
            MODE_JOYSTICK: begin
                raw_p1 = analog_x_p1;
                raw_p2 = analog_x_p2;
            end
            MODE_PADDLE: begin
                raw_p1 = paddle_p1 - PADDLE_CENTER;  // Wraps around the midpoint
                raw_p2 = paddle_p2 - PADDLE_CENTER;
            end
            MODE_SPINNER: begin
                abs_next = 1'b0;
                inc_next = |spin_flip;
                // Stale delta without a flip reads as no motion
                if (spin_flip[0]) begin
                    raw_p1 = spinner_p1[ANALOG_W-1:0];
                end
                if (spin_flip[1]) begin
                    raw_p2 = spinner_p2[ANALOG_W-1:0];
                end
            end
            MODE_DPAD: begin
                raw_p1 = dpad_rate(dpad_p1);
                raw_p2 = dpad_rate(dpad_p2);
            end
        endcase
    end

    //==============================
    // Output registers
    //==============================
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            prev_toggle <= '0;
            analog_p1   <= '0;
            analog_p2   <= '0;
            analog_abs  <= 1'b0;
            analog_inc  <= 1'b0;
        end else begin
            // Toggles tracked in every mode so a mode change sees no false edge
            prev_toggle <= {spinner_p2[SPIN_W-1], spinner_p1[SPIN_W-1]};
            analog_p1   <= sens_scale(raw_p1, analog_sens, analog_invert);
            analog_p2   <= sens_scale(raw_p2, analog_sens, analog_invert);
            analog_abs  <= abs_next;
            analog_inc  <= inc_next;
        end
    end

    // Board must never see both position kinds at once
    a_abs_inc_excl: assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        !(analog_abs && analog_inc)
    );

    // Incremental report only follows a spinner-mode sample
    a_inc_from_spinner: assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        analog_inc |-> ($past(analog_mode) == MODE_SPINNER)
    );

endmodule
